// ==== fir.f ====
+incdir+hdl
hdl/fir_cfg_pkg.sv
hdl/fir_core_pkg.sv
hdl/fir_axil_regs.sv
hdl/fir_engine.sv
hdl/fir.sv
tb/tb_clkgen.sv
tb/tb_bram.sv
tb/tb_fir.sv

// ==== Bender.yml ====
package:
  name: fir

sources:
  # rtl, packages first
  - include_dirs:
      - hdl
    files:
      - hdl/fir_cfg_pkg.sv
      - hdl/fir_core_pkg.sv
      - hdl/fir_axil_regs.sv
      - hdl/fir_engine.sv
      - hdl/fir.sv
  # testbench, top is tb_fir
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_clkgen.sv
      - tb/tb_bram.sv
      - tb/tb_fir.sv

// ==== tb/tb_fir.sv ====
`timescale 1ns/100ps
`include "fir_consts.svh"

module tb_fir;

    localparam int NUM_RUNS = 3;
    // slack for register traffic and history clears
    localparam int TIMEOUT_BASE = 2000;

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awready;
    logic                   wready;
    logic                   awvalid;
    logic [`FIR_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [`FIR_DATA_W-1:0] wdata;
    logic                   arready;
    logic                   rready;
    logic                   arvalid;
    logic [`FIR_ADDR_W-1:0] araddr;
    logic                   rvalid;
    logic [`FIR_DATA_W-1:0] rdata;
    logic                   ss_tvalid;
    logic [`FIR_DATA_W-1:0] ss_tdata;
    logic                   ss_tready;
    logic                   sm_tready;
    logic                   sm_tvalid;
    logic [`FIR_DATA_W-1:0] sm_tdata;
    logic                   sm_tlast;
    logic [3:0]             tap_we;
    logic                   tap_en;
    logic [`FIR_DATA_W-1:0] tap_di;
    logic [`FIR_ADDR_W-1:0] tap_a;
    logic [`FIR_DATA_W-1:0] tap_do;
    logic [3:0]             data_we;
    logic                   data_en;
    logic [`FIR_DATA_W-1:0] data_di;
    logic [`FIR_ADDR_W-1:0] data_a;
    logic [`FIR_DATA_W-1:0] data_do;

    // two tap sets back to back, second one has a wrapping coefficient
    int tap_table [22] = '{
        3, -1, 4, 1, -5, 9, 2, -6, 5, 3, -5,
        65536, -7, 100, 0, -1, 12345, 7, -300, 2, 1, 'h7fff0000
    };
    // frame of 16 then frame of 20
    int sample_table [36] = '{
        1, -2, 3, 100, -100, 32767, -32768, 7,
        0, 5, 123456, -9, 11, 2, 1000000, -1,
        'h7fffffff, 'h80000000, -1, 1, 2, 3, 4, 5, 'h12345678, -77,
        40000, -40000, 9, 8, 7, 6, 65535, -65536, 0, 42
    };
    // per run: tap set, frame, length, output back-pressure
    int run_tap_base [NUM_RUNS]     = '{0, 0, 11};
    int run_samp_base [NUM_RUNS]    = '{0, 0, 16};
    int run_len [NUM_RUNS]          = '{16, 16, 20};
    int run_backpressure [NUM_RUNS] = '{0, 1, 1};

    logic [`FIR_DATA_W-1:0] exp_q [$];
    logic [31:0]            gap_state = 32'd24370;
    logic [31:0]            drop_state = 32'd24370;
    int                     errors = 0;
    int                     checks = 0;
    int                     cycle_cnt = 0;
    int                     cycle_limit = TIMEOUT_BASE;

    tb_clkgen u_clkgen (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n)
    );

    tb_bram u_tap_ram (
        .axis_clk (axis_clk),
        .we       (tap_we),
        .en       (tap_en),
        .di       (tap_di),
        .a        (tap_a),
        .dout     (tap_do)
    );

    tb_bram u_data_ram (
        .axis_clk (axis_clk),
        .we       (data_we),
        .en       (data_en),
        .di       (data_di),
        .a        (data_a),
        .dout     (data_do)
    );

    fir UUT (
        .awready    (awready),
        .wready     (wready),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .arready    (arready),
        .rready     (rready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .tap_we     (tap_we),
        .tap_en     (tap_en),
        .tap_di     (tap_di),
        .tap_a      (tap_a),
        .tap_do     (tap_do),
        .data_we    (data_we),
        .data_en    (data_en),
        .data_di    (data_di),
        .data_a     (data_a),
        .data_do    (data_do),
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 1 ns past the edge, outputs settled for this cycle
    task automatic next_cycle();
        @(posedge axis_clk);
        #1;
    endtask

    task automatic reg_write(input logic [`FIR_ADDR_W-1:0] addr,
                             input logic [`FIR_DATA_W-1:0] data);
        awvalid = 1'b1;
        awaddr  = addr;
        while (!awready) next_cycle();
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b1;
        wdata   = data;
        while (!wready) next_cycle();
        next_cycle();
        wvalid = 1'b0;
    endtask

    task automatic reg_read(input logic [`FIR_ADDR_W-1:0] addr,
                            output logic [`FIR_DATA_W-1:0] data);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready) next_cycle();
        next_cycle();
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) next_cycle();
        data = rdata;
        next_cycle();
        rready = 1'b0;
    endtask

    // direct 11-tap convolution, zero history before the frame, 32-bit wrap
    task automatic build_expected(input int run);
        int          n;
        int          k;
        logic [31:0] acc;
        logic [31:0] tap;
        logic [31:0] samp;
        exp_q.delete();
        for (n = 0; n < run_len[run]; n++) begin
            acc = '0;
            for (k = 0; k < `FIR_NUM_TAPS; k++) begin
                if (n - k >= 0) begin
                    tap  = tap_table[run_tap_base[run] + k];
                    samp = sample_table[run_samp_base[run] + n - k];
                    acc  = acc + tap * samp;
                end
            end
            exp_q.push_back(acc);
        end
    endtask

    // random idle cycles once the engine is ready
    task automatic drive_samples(input int run);
        int i;
        int gap;
        for (i = 0; i < run_len[run]; i++) begin
            while (!ss_tready) next_cycle();
            gap_state = xorshift32(gap_state);
            gap = gap_state[1:0];
            repeat (gap) next_cycle();
            ss_tvalid = 1'b1;
            ss_tdata  = sample_table[run_samp_base[run] + i];
            while (!ss_tready) next_cycle();
            next_cycle();
            ss_tvalid = 1'b0;
        end
    endtask

    // checks order, tlast and stability of a held output
    task automatic collect_results(input int run);
        int          count;
        logic        held;
        logic        held_last;
        logic [31:0] held_data;
        logic        exp_last;
        count     = 0;
        held      = 1'b0;
        held_last = 1'b0;
        held_data = '0;
        while (count < run_len[run]) begin
            if (run_backpressure[run] != 0) begin
                drop_state = xorshift32(drop_state);
                sm_tready  = (drop_state[1:0] != 2'b00);
            end else begin
                sm_tready = 1'b1;
            end
            if (held) begin
                checks++;
                if (sm_tvalid !== 1'b1) begin
                    errors++;
                    $display("[FAIL] %0t sm_tvalid: expected 1, got %b (dropped while held)",
                             $time, sm_tvalid);
                end else begin
                    if (sm_tdata !== held_data) begin
                        errors++;
                        $display("[FAIL] %0t sm_tdata: expected %h, got %h (changed while held)",
                                 $time, held_data, sm_tdata);
                    end
                    checks++;
                    if (sm_tlast !== held_last) begin
                        errors++;
                        $display("[FAIL] %0t sm_tlast: expected %b, got %b (changed while held)",
                                 $time, held_last, sm_tlast);
                    end
                end
            end
            if (sm_tvalid === 1'b1 && sm_tready) begin
                exp_last = (count == run_len[run] - 1);
                checks++;
                if (sm_tdata !== exp_q[count]) begin
                    errors++;
                    $display("[FAIL] %0t sm_tdata[%0d]: expected %h, got %h",
                             $time, count, exp_q[count], sm_tdata);
                end
                checks++;
                if (sm_tlast !== exp_last) begin
                    errors++;
                    $display("[FAIL] %0t sm_tlast[%0d]: expected %b, got %b",
                             $time, count, exp_last, sm_tlast);
                end
                count++;
                held = 1'b0;
            end else begin
                held      = (sm_tvalid === 1'b1);
                held_data = sm_tdata;
                held_last = sm_tlast;
            end
            next_cycle();
        end
        sm_tready = 1'b0;
    endtask

    // tap window is closed while the engine runs
    task automatic poke_while_running();
        logic [31:0] rd;
        repeat (3) next_cycle();
        reg_read(`FIR_REG_CTRL, rd);
        checks++;
        if (rd !== 32'h0) begin
            errors++;
            $display("[FAIL] %0t ctrl (running): expected %h, got %h", $time, 32'h0, rd);
        end
        reg_write(`FIR_REG_TAP_BASE + 12'd12, 32'hdeadbeef);
        reg_read(`FIR_REG_TAP_BASE + 12'd12, rd);
        checks++;
        if (rd !== 32'h0) begin
            errors++;
            $display("[FAIL] %0t tap[3] (running): expected %h, got %h", $time, 32'h0, rd);
        end
    endtask

    task automatic check_taps(input int run);
        int          i;
        logic [31:0] rd;
        logic [31:0] exp_tap;
        for (i = 0; i < `FIR_NUM_TAPS; i++) begin
            reg_read(`FIR_REG_TAP_BASE + 4 * i, rd);
            exp_tap = tap_table[run_tap_base[run] + i];
            checks++;
            if (rd !== exp_tap) begin
                errors++;
                $display("[FAIL] %0t tap[%0d]: expected %h, got %h", $time, i, exp_tap, rd);
            end
        end
    endtask

    // watchdog
    always @(posedge axis_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int          run;
        int          i;
        logic [31:0] rd;
        logic [31:0] exp_ctrl;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        sm_tready = 1'b0;
        // 20 cycles per sample on top of the base
        for (run = 0; run < NUM_RUNS; run++) begin
            cycle_limit += 20 * run_len[run];
        end

        wait (axis_rst_n === 1'b1);
        next_cycle();

        // out of reset: idle only
        exp_ctrl = 32'd1 << `FIR_CTRL_IDLE;
        reg_read(`FIR_REG_CTRL, rd);
        checks++;
        if (rd !== exp_ctrl) begin
            errors++;
            $display("[FAIL] %0t ctrl (reset): expected %h, got %h", $time, exp_ctrl, rd);
        end

        for (run = 0; run < NUM_RUNS; run++) begin
            build_expected(run);
            for (i = 0; i < `FIR_NUM_TAPS; i++) begin
                reg_write(`FIR_REG_TAP_BASE + 4 * i, tap_table[run_tap_base[run] + i]);
            end
            reg_write(`FIR_REG_LEN, run_len[run]);
            check_taps(run);
            reg_read(`FIR_REG_LEN, rd);
            checks++;
            if (rd !== run_len[run]) begin
                errors++;
                $display("[FAIL] %0t data_length: expected %h, got %h", $time, run_len[run], rd);
            end

            reg_write(`FIR_REG_CTRL, 32'd1 << `FIR_CTRL_START);
            fork
                drive_samples(run);
                collect_results(run);
                poke_while_running();
            join

            // done then idle, done clears on the first read
            exp_ctrl = (32'd1 << `FIR_CTRL_DONE) | (32'd1 << `FIR_CTRL_IDLE);
            reg_read(`FIR_REG_CTRL, rd);
            checks++;
            if (rd !== exp_ctrl) begin
                errors++;
                $display("[FAIL] %0t ctrl (done): expected %h, got %h", $time, exp_ctrl, rd);
            end
            exp_ctrl = 32'd1 << `FIR_CTRL_IDLE;
            reg_read(`FIR_REG_CTRL, rd);
            checks++;
            if (rd !== exp_ctrl) begin
                errors++;
                $display("[FAIL] %0t ctrl (reread): expected %h, got %h", $time, exp_ctrl, rd);
            end
            checks++;
            if (sm_tvalid !== 1'b0) begin
                errors++;
                $display("[FAIL] %0t sm_tvalid (after frame): expected 0, got %b",
                         $time, sm_tvalid);
            end
            // the write during the run must not have landed
            check_taps(run);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb/tb_bram.sv ====
`timescale 1ns/100ps
`include "fir_consts.svh"

module tb_bram (
    input  logic                   axis_clk,
    input  logic [3:0]             we,
    input  logic                   en,
    input  logic [`FIR_DATA_W-1:0] di,
    input  logic [`FIR_ADDR_W-1:0] a,
    output logic [`FIR_DATA_W-1:0] dout
);

    // word addressed, byte address bits dropped
    localparam int DEPTH = 1 << (`FIR_ADDR_W - 2);

    logic [`FIR_DATA_W-1:0] mem [DEPTH];

    // nonzero junk so a missing history clear shows up
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {i[15:0] ^ 16'ha5c3, ~i[15:0]};
        end
        dout = '0;
    end

    // read first, one cycle latency, byte enables on write
    always @(posedge axis_clk) begin
        if (en) begin
            dout <= mem[a[`FIR_ADDR_W-1:2]];
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[a[`FIR_ADDR_W-1:2]][8*b +: 8] <= di[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
    output logic axis_clk,
    output logic axis_rst_n
);

    // 8 ns period
    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    // reset held for 5 rising edges, released just after the last one
    initial begin
        axis_rst_n = 1'b0;
        repeat (5) @(posedge axis_clk);
        #1 axis_rst_n = 1'b1;
    end

endmodule

// ==== hdl/fir.sv ====
`timescale 1ns/100ps
`include "fir_consts.svh"

module fir (
    // register port
    output logic                   awready,
    output logic                   wready,
    input  logic                   awvalid,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    input  logic [`FIR_DATA_W-1:0] wdata,
    output logic                   arready,
    input  logic                   rready,
    input  logic                   arvalid,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    output logic [`FIR_DATA_W-1:0] rdata,
    // sample stream in
    input  logic                   ss_tvalid,
    input  logic [`FIR_DATA_W-1:0] ss_tdata,
    output logic                   ss_tready,
    // result stream out
    input  logic                   sm_tready,
    output logic                   sm_tvalid,
    output logic [`FIR_DATA_W-1:0] sm_tdata,
    output logic                   sm_tlast,
    // tap coefficient ram
    output logic [3:0]             tap_we,
    output logic                   tap_en,
    output logic [`FIR_DATA_W-1:0] tap_di,
    output logic [`FIR_ADDR_W-1:0] tap_a,
    input  logic [`FIR_DATA_W-1:0] tap_do,
    // sample history ram
    output logic [3:0]             data_we,
    output logic                   data_en,
    output logic [`FIR_DATA_W-1:0] data_di,
    output logic [`FIR_ADDR_W-1:0] data_a,
    input  logic [`FIR_DATA_W-1:0] data_do,
    input  logic                   axis_clk,
    input  logic                   axis_rst_n
);

    // start handshake and run status between the halves
    logic                   ap_start;
    logic                   start_ack;
    logic                   frame_done;
    logic                   running;
    logic [`FIR_DATA_W-1:0] data_length;
    logic [`FIR_IDX_W-1:0]  tap_idx;

    fir_axil_regs u_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .tap_we      (tap_we),
        .tap_en      (tap_en),
        .tap_di      (tap_di),
        .tap_a       (tap_a),
        .tap_do      (tap_do),
        .start_ack   (start_ack),
        .frame_done  (frame_done),
        .running     (running),
        .tap_idx     (tap_idx),
        .ap_start    (ap_start),
        .data_length (data_length)
    );

    // engine reads taps through the register block's ram port
    fir_engine u_engine (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tready   (ss_tready),
        .sm_tvalid   (sm_tvalid),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast),
        .sm_tready   (sm_tready),
        .data_we     (data_we),
        .data_en     (data_en),
        .data_di     (data_di),
        .data_a      (data_a),
        .data_do     (data_do),
        .tap_do      (tap_do),
        .tap_idx     (tap_idx),
        .ap_start    (ap_start),
        .data_length (data_length),
        .start_ack   (start_ack),
        .frame_done  (frame_done),
        .running     (running)
    );

endmodule

// ==== hdl/fir_engine.sv ====
`timescale 1ns/100ps
`include "fir_consts.svh"

module fir_engine
    import fir_core_pkg::*;
(
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    input  logic                   ss_tvalid,
    input  logic [`FIR_DATA_W-1:0] ss_tdata,
    output logic                   ss_tready,
    output logic                   sm_tvalid,
    output logic [`FIR_DATA_W-1:0] sm_tdata,
    output logic                   sm_tlast,
    input  logic                   sm_tready,
    output logic [3:0]             data_we,
    output logic                   data_en,
    output logic [`FIR_DATA_W-1:0] data_di,
    output logic [`FIR_ADDR_W-1:0] data_a,
    input  logic [`FIR_DATA_W-1:0] data_do,
    input  logic [`FIR_DATA_W-1:0] tap_do,
    output logic [`FIR_IDX_W-1:0]  tap_idx,
    input  logic                   ap_start,
    input  logic [`FIR_DATA_W-1:0] data_length,
    output logic                   start_ack,
    output logic                   frame_done,
    output logic                   running
);

    // last history slot / tap index
    localparam int LAST_IDX = `FIR_NUM_TAPS - 1;
    // mac steps 0..10 issue reads, 1..11 multiply, 2..12 accumulate
    localparam int MAC_END = `FIR_NUM_TAPS + 1;

    eng_state_e             state;
    eng_state_e             state_next;
    // clear slot in CLEAR, mac step in MAC
    logic [`FIR_IDX_W-1:0]  step;
    // slot for the next incoming sample
    logic [`FIR_IDX_W-1:0]  wr_slot;
    // slot read for the current tap, walks backwards
    logic [`FIR_IDX_W-1:0]  rd_slot;
    logic [`FIR_DATA_W-1:0] samp_cnt;
    logic                   last_q;
    logic [`FIR_DATA_W-1:0] prod;
    logic [`FIR_DATA_W-1:0] acc;
    logic                   in_hs;
    logic                   out_hs;
    logic                   issue;

    function automatic logic [`FIR_ADDR_W-1:0] slot_addr(input logic [`FIR_IDX_W-1:0] idx);
        return {{(`FIR_ADDR_W - `FIR_IDX_W - 2){1'b0}}, idx, 2'b00};
    endfunction

    assign ss_tready  = (state == ENG_INTAKE);
    assign sm_tvalid  = (state == ENG_OUTPUT);
    assign sm_tdata   = acc;
    assign sm_tlast   = sm_tvalid && last_q;
    assign in_hs      = ss_tvalid && ss_tready;
    assign out_hs     = sm_tvalid && sm_tready;
    assign issue      = (state == ENG_MAC) && (step <= LAST_IDX);
    assign tap_idx    = issue ? step : '0;
    assign start_ack  = (state == ENG_IDLE) && ap_start;
    assign frame_done = out_hs && last_q;
    assign running    = (state != ENG_IDLE);

    always_comb begin
        state_next = state;
        case (state)
            ENG_IDLE: begin
                if (ap_start) begin
                    state_next = ENG_CLEAR;
                end
            end
            ENG_CLEAR: begin
                if (step == LAST_IDX) begin
                    state_next = ENG_INTAKE;
                end
            end
            ENG_INTAKE: begin
                if (in_hs) begin
                    state_next = ENG_MAC;
                end
            end
            ENG_MAC: begin
                if (step == MAC_END) begin
                    state_next = ENG_OUTPUT;
                end
            end
            ENG_OUTPUT: begin
                if (sm_tready) begin
                    state_next = last_q ? ENG_IDLE : ENG_INTAKE;
                end
            end
            default: state_next = ENG_IDLE;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state    <= ENG_IDLE;
            step     <= '0;
            wr_slot  <= '0;
            rd_slot  <= '0;
            samp_cnt <= '0;
            last_q   <= 1'b0;
        end else begin
            state <= state_next;
            // step only counts while staying in clear or mac
            if ((state == ENG_CLEAR || state == ENG_MAC) && state_next == state) begin
                step <= step + 1'b1;
            end else begin
                step <= '0;
            end
            if (start_ack) begin
                wr_slot  <= '0;
                samp_cnt <= '0;
            end else if (in_hs) begin
                wr_slot  <= (wr_slot == LAST_IDX) ? '0 : wr_slot + 1'b1;
                samp_cnt <= samp_cnt + 1'b1;
                // newest sample is tap 0's operand
                rd_slot  <= wr_slot;
                last_q   <= (samp_cnt + 1'b1 == data_length);
            end else if (issue) begin
                rd_slot <= (rd_slot == '0) ? LAST_IDX[`FIR_IDX_W-1:0] : rd_slot - 1'b1;
            end
        end
    end

    // multiply one step behind the reads, accumulate one behind that
    // wraps to 32 bits
    always_ff @(posedge axis_clk) begin
        if (in_hs) begin
            acc <= '0;
        end else if (state == ENG_MAC && step >= 2) begin
            acc <= acc + prod;
        end
        if (state == ENG_MAC && step >= 1 && step <= `FIR_NUM_TAPS) begin
            prod <= $signed(tap_do) * $signed(data_do);
        end
    end

    // history ram port
    always_comb begin
        data_en = 1'b0;
        data_we = '0;
        data_di = ss_tdata;
        data_a  = slot_addr(wr_slot);
        case (state)
            ENG_CLEAR: begin
                data_en = 1'b1;
                data_we = `FIR_WE_ALL;
                data_di = '0;
                data_a  = slot_addr(step);
            end
            ENG_INTAKE: begin
                data_en = in_hs;
                data_we = in_hs ? `FIR_WE_ALL : 4'b0000;
            end
            ENG_MAC: begin
                data_en = issue;
                data_a  = slot_addr(rd_slot);
            end
            default: begin
                data_en = 1'b0;
            end
        endcase
    end

endmodule

// ==== hdl/fir_axil_regs.sv ====
`timescale 1ns/100ps
`include "fir_consts.svh"

module fir_axil_regs
    import fir_cfg_pkg::*;
(
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [`FIR_DATA_W-1:0] wdata,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`FIR_DATA_W-1:0] rdata,
    output logic [3:0]             tap_we,
    output logic                   tap_en,
    output logic [`FIR_DATA_W-1:0] tap_di,
    output logic [`FIR_ADDR_W-1:0] tap_a,
    input  logic [`FIR_DATA_W-1:0] tap_do,
    input  logic                   start_ack,
    input  logic                   frame_done,
    input  logic                   running,
    input  logic [`FIR_IDX_W-1:0]  tap_idx,
    output logic                   ap_start,
    output logic [`FIR_DATA_W-1:0] data_length
);

    wr_state_e              wr_state;
    rd_state_e              rd_state;
    rd_state_e              rd_next;
    reg_sel_e               wr_sel;
    reg_sel_e               rd_sel;
    reg_sel_e               ar_sel;
    logic [`FIR_ADDR_W-1:0] wr_addr;
    logic [`FIR_ADDR_W-1:0] rd_addr;
    logic [`FIR_DATA_W-1:0] rdata_q;
    logic [`FIR_DATA_W-1:0] status;
    logic                   tap_capture;
    logic                   ap_done;
    logic                   ap_idle;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   ar_hs;
    logic                   tap_wr;

    function automatic reg_sel_e decode_sel(input logic [`FIR_ADDR_W-1:0] addr);
        reg_sel_e sel;
        if (addr == `FIR_REG_CTRL) begin
            sel = SEL_CTRL;
        end else if (addr == `FIR_REG_LEN) begin
            sel = SEL_LEN;
        end else if (addr >= `FIR_REG_TAP_BASE && addr[1:0] == 2'b00 &&
                     addr <= `FIR_REG_TAP_BASE + 4 * (`FIR_NUM_TAPS - 1)) begin
            sel = SEL_TAP;
        end else begin
            sel = SEL_NONE;
        end
        return sel;
    endfunction

    // write side, w stalls while a tap read owns the ram port
    assign awready = (wr_state == WR_ADDR);
    assign wready  = (wr_state == WR_DATA) && !(wr_sel == SEL_TAP && rd_state == RD_FETCH);
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    // tap writes only land while idle
    assign tap_wr  = w_hs && wr_sel == SEL_TAP && ap_idle;

    assign ar_hs   = arvalid && arready;
    assign ar_sel  = decode_sel(araddr);
    assign rvalid  = (rd_state == RD_RESP);
    // bram output straight through on the first resp cycle, then the copy
    assign rdata   = tap_capture ? tap_do : rdata_q;

    always_comb begin
        status = '0;
        status[`FIR_CTRL_START] = ap_start;
        status[`FIR_CTRL_DONE]  = ap_done;
        status[`FIR_CTRL_IDLE]  = ap_idle;
    end

    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_ADDR: begin
                if (ar_hs) begin
                    // during a run a tap read skips the ram and returns zero
                    rd_next = (ar_sel == SEL_TAP && ap_idle) ? RD_FETCH : RD_RESP;
                end
            end
            RD_FETCH: rd_next = RD_RESP;
            RD_RESP: begin
                if (rready) begin
                    rd_next = RD_ADDR;
                end
            end
            default: rd_next = RD_ADDR;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_state    <= WR_ADDR;
            rd_state    <= RD_ADDR;
            arready     <= 1'b0;
            tap_capture <= 1'b0;
        end else begin
            if (aw_hs) begin
                wr_state <= WR_DATA;
            end else if (w_hs) begin
                wr_state <= WR_ADDR;
            end
            rd_state    <= rd_next;
            arready     <= (rd_next == RD_ADDR);
            tap_capture <= (rd_state == RD_FETCH);
        end
    end

    // latched targets and read data
    always_ff @(posedge axis_clk) begin
        if (aw_hs) begin
            wr_sel  <= decode_sel(awaddr);
            wr_addr <= awaddr - `FIR_REG_TAP_BASE;
        end
        if (ar_hs) begin
            rd_sel  <= ar_sel;
            rd_addr <= araddr - `FIR_REG_TAP_BASE;
            case (ar_sel)
                SEL_CTRL: rdata_q <= status;
                SEL_LEN:  rdata_q <= data_length;
                default:  rdata_q <= '0;
            endcase
        end else if (tap_capture) begin
            rdata_q <= tap_do;
        end
    end

    // control word and length
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start    <= 1'b0;
            ap_done     <= 1'b0;
            ap_idle     <= 1'b1;
            data_length <= '0;
        end else begin
            if (start_ack) begin
                ap_start <= 1'b0;
            end else if (w_hs && wr_sel == SEL_CTRL && ap_idle && wdata[`FIR_CTRL_START]) begin
                ap_start <= 1'b1;
            end
            if (frame_done) begin
                ap_done <= 1'b1;
            end else if (rvalid && rready && rd_sel == SEL_CTRL) begin
                ap_done <= 1'b0;
            end
            // follows the engine's next running state
            ap_idle <= !((running && !frame_done) || start_ack);
            if (w_hs && wr_sel == SEL_LEN && ap_idle) begin
                data_length <= wdata;
            end
        end
    end

    // single tap ram port
    // fetch first, it can only overlap the engine's clear phase
    always_comb begin
        tap_en = 1'b0;
        tap_we = '0;
        tap_di = wdata;
        tap_a  = wr_addr;
        if (rd_state == RD_FETCH) begin
            tap_en = 1'b1;
            tap_a  = rd_addr;
        end else if (!ap_idle) begin
            tap_en = 1'b1;
            tap_a  = {{(`FIR_ADDR_W - `FIR_IDX_W - 2){1'b0}}, tap_idx, 2'b00};
        end else if (tap_wr) begin
            tap_en = 1'b1;
            tap_we = `FIR_WE_ALL;
        end
    end

endmodule

// ==== hdl/fir_core_pkg.sv ====
package fir_core_pkg;

    // engine sequence
    // idle -> clear history -> (intake -> mac -> output)* -> idle
    typedef enum logic [2:0] {
        ENG_IDLE,
        // zero the history ram, one slot per cycle
        ENG_CLEAR,
        // waiting for a sample
        ENG_INTAKE,
        // tap reads plus pipeline drain
        ENG_MAC,
        // result held until sm handshake
        ENG_OUTPUT
    } eng_state_e;

endpackage

// ==== hdl/fir_cfg_pkg.sv ====
package fir_cfg_pkg;

    // decoded register target
    typedef enum logic [1:0] {
        SEL_CTRL,
        SEL_LEN,
        SEL_TAP,
        SEL_NONE
    } reg_sel_e;

    // aw then w, one after the other
    typedef enum logic {
        WR_ADDR,
        WR_DATA
    } wr_state_e;

    // fetch only used for tap reads, covers bram latency
    typedef enum logic [1:0] {
        RD_ADDR,
        RD_FETCH,
        RD_RESP
    } rd_state_e;

endpackage

// ==== hdl/fir_consts.svh ====
`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

// bus and bram widths
`define FIR_ADDR_W 12
`define FIR_DATA_W 32

// filter size and index width for taps / history slots
`define FIR_NUM_TAPS 11
`define FIR_IDX_W 4

// register map byte offsets
`define FIR_REG_CTRL 12'h000
`define FIR_REG_LEN 12'h010
// tap i sits at base + 4*i, last one at 0x48
`define FIR_REG_TAP_BASE 12'h020

// control word bits
`define FIR_CTRL_START 0
`define FIR_CTRL_DONE 1
`define FIR_CTRL_IDLE 2

// bram byte enables, full word
`define FIR_WE_ALL 4'b1111

`endif
